/* dv/reflectorTests.svh */
// reflector directed tests
// frame driver, reply model and the test tasks for the reflector

`ifndef REFLECTOR_TESTS_SVH
`define REFLECTOR_TESTS_SVH

task automatic buildFrame(input int len);
  integer randomBits;
  frameWords.delete();
  for (int i = 0; i < len; i++) begin
    randomBits = $random(seed);
    frameWords.push_back(word_t'(randomBits));
  end
endtask

task automatic driveFrame();
  gotData.delete();  // fresh reply for every frame
  gotLast.delete();
  repliesSeen = 0;
  for (int i = 0; i < frameWords.size(); i++) begin
    @(posedge clk);
    rxIn.data  <= frameWords[i];
    rxIn.valid <= 1'b1;
    rxIn.last  <= (i == frameWords.size() - 1);
  end
  @(posedge clk);
  rxIn <= '0;
endtask

// header as is, then the instret count shifted by half a word
function automatic word_t expectedWord(input int i);
  if (i < HeaderWords) return frameWords[i];
  else if (i == HeaderWords)
    return {frameWords[CountWord + 1][15:0], frameWords[CountWord][31:16]};
  else if (i == HeaderWords + 1)
    return {frameWords[CountWord + 2][15:0], frameWords[CountWord + 1][31:16]};
  return word_t'(1);
endfunction

task automatic toggleReady();
  int cycles = 0;
  integer randomBits;
  while (repliesSeen == 0 && cycles < ReplyLimit) begin
    @(posedge clk);
    randomBits = $random(seed);
    txReady <= randomBits[0];
    cycles++;
  end
  txReady <= 1'b1;
endtask

task automatic checkReply(input string name);
  int cycles = 0;
  while (repliesSeen == 0 && cycles < ReplyLimit) begin
    @(negedge clk);
    cycles++;
  end
  if (repliesSeen == 0) begin
    $display("%s: no reply arrived within %0d cycles", name, ReplyLimit);
    failureCount++;
  end else if (gotData.size() != ReplyWords) begin
    $display("%s: reply held %0d words instead of %0d", name, gotData.size(), ReplyWords);
    failureCount++;
  end else begin
    for (int i = 0; i < ReplyWords; i++) begin
      checkWord($sformatf("%s word %0d", name, i), gotData[i], expectedWord(i));
      checkFlag($sformatf("%s last %0d", name, i), gotLast[i], i == ReplyWords - 1);
    end
  end
  repeat (2) @(posedge clk);  // transmit FSM back to ready
endtask

////////////////////
// tests

task automatic idleAfterReset();
  repeat (20) begin
    @(negedge clk);
    checkFlag("idle valid", txOut.valid, 1'b0);
    checkFlag("idle last", txOut.last, 1'b0);
  end
endtask

task automatic singleFrameReady();
  @(posedge clk);
  txReady <= 1'b1;
  buildFrame(RecvWords);
  driveFrame();
  @(negedge clk);
  checkFlag("first word one cycle late", txOut.valid, 1'b1);
  checkReply("ready frame");
endtask

task automatic frameUnderBackPressure();
  repeat (3) begin
    txReady <= 1'b0;  // low when capture ends
    buildFrame(RecvWords);
    driveFrame();
    toggleReady();
    checkReply("stalled frame");
  end
endtask

task automatic longFrame();
  txReady <= 1'b1;
  buildFrame(RecvWords + 3);
  driveFrame();
  checkReply("long frame");
endtask

task automatic dropEverySixteenth();
  applyReset();
  txReady <= 1'b1;
  for (int f = 0; f < 16; f++) begin
    buildFrame(RecvWords);
    driveFrame();
    if (f == DropIndex) begin
      repeat (ReplyWords + 4) @(negedge clk);
      if (gotData.size() != 0) begin
        $display("reply %0d was sent although it should have been dropped", f);
        failureCount++;
      end
    end else begin
      checkReply($sformatf("frame %0d", f));
    end
  end
endtask

`endif

/* dv/reflectorTb.sv */
// reflector testbench
// drives trace frames into the reflector and checks each reply
// against the frame layout rule

`timescale 1ns/1ns

module reflectorTb import reflectorPkg::*; ();

  localparam int FrameCountWidth = 4;
  localparam int DropIndex       = 10;
  localparam int ReplyLimit      = 200;           // cycles to wait for one reply
  localparam int WatchdogNs      = 40 * 60 * 20;  // 40 frames of 60 cycles

  logic    clk;
  logic    reset;
  rxBeat_t rxIn;
  logic    txReady;
  txBeat_t txOut;

  integer seed = 32'h4d03;
  int     mismatchCount = 0;
  int     failureCount = 0;

  // transferred reply words
  word_t gotData[$];
  logic  gotLast[$];
  int    repliesSeen = 0;

  word_t frameWords[$];  // frame under test

  reflectorTop #(
    .FrameCountWidth (FrameCountWidth),
    .DropIndex       (DropIndex)
  ) reflectorTop_inst (
    .clk     (clk),
    .reset   (reset),
    .rxIn    (rxIn),
    .txReady (txReady),
    .txOut   (txOut)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // output monitor, a word moves when valid and ready meet
  always @(posedge clk) begin
    if (txOut.valid && txReady) begin
      gotData.push_back(txOut.data);
      gotLast.push_back(txOut.last);
      if (txOut.last) repliesSeen++;
    end
  end

  ////////////////////
  // compare tasks

  task automatic checkWord(input string what, input word_t got, input word_t expected);
    if (got !== expected) begin
      $display("MISMATCH at %0t ns: %s got %h, expected %h", $time, what, got, expected);
      mismatchCount++;
    end
  endtask

  task automatic checkFlag(input string what, input logic got, input logic expected);
    if (got !== expected) begin
      $display("MISMATCH at %0t ns: %s got %b, expected %b", $time, what, got, expected);
      mismatchCount++;
    end
  endtask

  task automatic applyReset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  endtask

  `include "reflectorTests.svh"

  ////////////////////
  // test sequence

  initial begin
    rxIn    = '0;
    txReady = 1'b0;
    reset   = 1'b1;
    applyReset();
    idleAfterReset();
    singleFrameReady();
    frameUnderBackPressure();
    longFrame();
    dropEverySixteenth();
    repeat (4) @(posedge clk);
    $display("errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
    if (mismatchCount == 0 && failureCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("timeout: the tests did not finish within %0d ns", WatchdogNs);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* reflectorTop.f */
src/reflectorPkg.sv
src/frameCapture.sv
src/replyBuilder.sv
src/reflectorCtrl.sv
src/reflectorTop.sv
+incdir+dv
dv/reflectorTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the reflector testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module reflectorTb -f reflectorTop.f \
  -Mdir obj_dir -o reflectorSim

./obj_dir/reflectorSim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "reflector run passed"
else
  echo "reflector run failed"
  exit 1
fi

/* src/frameCapture.sv */
// frame capture store
// holds the first twelve words of a frame, written by word index

`timescale 1ns/1ns

module frameCapture import reflectorPkg::*; (
  input  logic                    clk,
  input  logic                    captureEn,
  input  captureIndex_t           captureIndex,
  input  word_t                   captureData,
  output word_t [RecvWords-1:0]   capturedWords
);

  word_t [RecvWords-1:0] store;

  // one register per captured word
  always_ff @(posedge clk) begin
    for (int i = 0; i < RecvWords; i++) begin
      if (captureEn && captureIndex == captureIndex_t'(i)) begin
        store[i] <= captureData;
      end
    end
  end

  assign capturedWords = store;

  // the store is only twelve deep, a write past it would be lost
  writeInStore: assert property (@(posedge clk)
    captureEn |-> (captureIndex < captureIndex_t'(RecvWords)));

endmodule

/* src/reflectorCtrl.sv */
// reflector control
// receive FSM with the capture word counter, transmit FSM with the
// reply index, and the reply counter that drops one reply out of
// every sixteen

`timescale 1ns/1ns

module reflectorCtrl import reflectorPkg::*; #(
  parameter int FrameCountWidth = 4,
  parameter int DropIndex       = 10
) (
  input  logic          clk,
  input  logic          reset,
  input  rxBeat_t       rxIn,
  input  logic          txReady,
  output logic          captureEn,
  output captureIndex_t captureIndex,
  output replyIndex_t   replyIndex,
  input  word_t         replyWord,
  output txBeat_t       txOut
);

  recvState_e  recvState, recvNext;
  transState_e transState, transNext;

  logic countEn;
  logic countClear;
  logic captureDone;
  logic indexLast;
  logic dropReply;

  logic [FrameCountWidth-1:0] replyCount;

  ////////////////////
  // receive side

  always_ff @(posedge clk) begin
    if (reset) recvState <= recvIdle;
    else recvState <= recvNext;
  end

  always_comb begin
    recvNext = recvState;
    case (recvState)
      recvIdle: begin
        if (rxIn.valid) recvNext = recvCapture;
      end
      recvCapture: begin
        // a twelve word frame ends on its capture word
        if (captureDone && rxIn.last) recvNext = recvDone;
        else if (captureDone) recvNext = recvCaptureDone;
      end
      recvCaptureDone: begin
        if (rxIn.valid && rxIn.last) recvNext = recvDone;
      end
      recvDone: begin
        if (rxIn.valid) recvNext = recvCapture;
        else recvNext = recvIdle;
      end
      default: recvNext = recvIdle;
    endcase
  end

  assign countEn    = rxIn.valid && (recvState != recvCaptureDone);
  assign countClear = (recvState == recvIdle || recvState == recvDone) && !rxIn.valid;

  always_ff @(posedge clk) begin
    if (reset || countClear) captureIndex <= '0;
    else if (countEn) captureIndex <= captureIndex + 1'b1;
  end

  assign captureEn   = countEn;  // word k lands at index k
  assign captureDone = rxIn.valid && (captureIndex == captureIndex_t'(RecvWords - 1));

  ////////////////////
  // transmit side

  always_ff @(posedge clk) begin
    if (reset) transState <= transReady;
    else transState <= transNext;
  end

  always_comb begin
    transNext = transState;
    case (transState)
      transReady: begin
        if (captureDone && txReady) transNext = transSend;
        else if (captureDone) transNext = transWait;
      end
      transWait: begin
        if (txReady) transNext = transSend;
      end
      transSend: begin
        if (indexLast && txReady) transNext = transFinished;
      end
      transFinished: transNext = transReady;  // one cycle only
      default: transNext = transReady;
    endcase
  end

  assign indexLast = (replyIndex == replyIndex_t'(ReplyWords - 1));

  // index moves on ready even when the reply is dropped
  always_ff @(posedge clk) begin
    if (reset || transState == transReady) replyIndex <= '0;
    else if (transState == transSend && txReady) replyIndex <= replyIndex + 1'b1;
  end

  // reply counter wraps, so the drop repeats
  always_ff @(posedge clk) begin
    if (reset) replyCount <= '0;
    else if (transState == transFinished) replyCount <= replyCount + 1'b1;
  end

  assign dropReply = (replyCount == FrameCountWidth'(DropIndex));

  assign txOut.data  = replyWord;
  assign txOut.valid = (transState == transSend) && !dropReply;
  assign txOut.last  = (transState == transSend) && !dropReply && indexLast;

  ////////////////////
  // checks

  // a stalled word holds until the MAC takes it
  stallHoldsWord: assert property (@(posedge clk) disable iff (reset)
    (txOut.valid && !txReady) |=>
      (txOut.valid && $stable(txOut.data) && $stable(txOut.last)));

  // a reply is dropped whole or not at all
  dropHoldsInReply: assert property (@(posedge clk) disable iff (reset)
    (transState == transSend) |=> $stable(dropReply));

  captureInRange: assert property (@(posedge clk) disable iff (reset)
    captureEn |-> (captureIndex < captureIndex_t'(RecvWords)));

endmodule

/* src/reflectorPkg.sv */
// reflector package
// word types, stream beat structs, FSM state enums and the
// frame layout constants shared by the trace-frame reflector

package reflectorPkg;

  ////////////////////
  // word types

  typedef logic [31:0] word_t;      // one stream data word
  typedef logic [15:0] halfWord_t;  // half word, used by the reply layout

  typedef logic [3:0] captureIndex_t;  // index into the capture store
  typedef logic [2:0] replyIndex_t;    // index into the reply

  ////////////////////
  // stream beats

  // receive side beat, no ready on this side
  typedef struct packed {
    word_t data;
    logic  valid;
    logic  last;
  } rxBeat_t;

  // transmit side beat, stalled by the MAC ready level
  typedef struct packed {
    word_t data;
    logic  valid;
    logic  last;
  } txBeat_t;

  ////////////////////
  // state machines

  typedef enum logic [1:0] {
    recvIdle,
    recvCapture,
    recvCaptureDone,  // capture full, skipping to end of frame
    recvDone
  } recvState_e;

  typedef enum logic [1:0] {
    transReady,
    transWait,      // capture done but MAC not ready yet
    transSend,
    transFinished
  } transState_e;

  ////////////////////
  // frame layout

  localparam int RecvWords   = 12;  // words captured per frame
  localparam int ReplyWords  = 7;   // words sent back per reply
  localparam int HeaderWords = 4;   // header words copied as is
  localparam int CountWord   = 8;   // first word of the instret count

endpackage

/* src/reflectorTop.sv */
// trace-frame reflector top
// captures the head of each incoming trace frame and sends back
// a short reply with the header and the retired-instruction count

`timescale 1ns/1ns

module reflectorTop import reflectorPkg::*; #(
  parameter int FrameCountWidth = 4,
  parameter int DropIndex       = 10
) (
  input  logic    clk,
  input  logic    reset,
  input  rxBeat_t rxIn,
  input  logic    txReady,
  output txBeat_t txOut
);

  logic                  captureEn;
  captureIndex_t         captureIndex;
  word_t [RecvWords-1:0] capturedWords;
  replyIndex_t           replyIndex;
  word_t                 replyWord;

  ////////////////////
  // control

  reflectorCtrl #(
    .FrameCountWidth (FrameCountWidth),
    .DropIndex       (DropIndex)
  ) reflectorCtrl_inst (
    .clk          (clk),
    .reset        (reset),
    .rxIn         (rxIn),
    .txReady      (txReady),
    .captureEn    (captureEn),
    .captureIndex (captureIndex),
    .replyIndex   (replyIndex),
    .replyWord    (replyWord),
    .txOut        (txOut)
  );

  ////////////////////
  // datapath

  frameCapture frameCapture_inst (
    .clk           (clk),
    .captureEn     (captureEn),
    .captureIndex  (captureIndex),
    .captureData   (rxIn.data),
    .capturedWords (capturedWords)
  );

  replyBuilder replyBuilder_inst (
    .capturedWords (capturedWords),
    .replyIndex    (replyIndex),
    .replyWord     (replyWord)
  );

endmodule

/* src/replyBuilder.sv */
// reply builder
// lays out the seven reply words from the captured frame
// and picks one of them by reply index

`timescale 1ns/1ns

module replyBuilder import reflectorPkg::*; (
  input  word_t [RecvWords-1:0] capturedWords,
  input  replyIndex_t           replyIndex,
  output word_t                 replyWord
);

  word_t [ReplyWords-1:0] replyMap;

  // instret halves, the count starts mid word in the trace frame
  halfWord_t countHi0;  // upper half of word 8
  halfWord_t countLo1;  // lower half of word 9
  halfWord_t countHi1;  // upper half of word 9
  halfWord_t countLo2;  // lower half of word 10

  assign countHi0 = capturedWords[CountWord][31:16];
  assign countLo1 = capturedWords[CountWord + 1][15:0];
  assign countHi1 = capturedWords[CountWord + 1][31:16];
  assign countLo2 = capturedWords[CountWord + 2][15:0];

  always_comb begin
    // mac addresses, ethertype and frame count
    for (int i = 0; i < HeaderWords; i++) begin
      replyMap[i] = capturedWords[i];
    end
    replyMap[HeaderWords]     = {countLo1, countHi0};  // instret low word
    replyMap[HeaderWords + 1] = {countLo2, countHi1};  // instret high word
    replyMap[HeaderWords + 2] = word_t'(1);
  end

  // index 7 only shows up after the last word, reads as zero
  assign replyWord = (replyIndex < replyIndex_t'(ReplyWords)) ? replyMap[replyIndex] : '0;

endmodule
